// ==== filelist.f ====
z80_bus_pkg.sv
z80_req_intake.sv
z80_tstate_seq.sv
z80_strobe_gen.sv
z80_bus_bridge.sv
tb_z80_bus_device.sv
tb_z80_bus_bridge.sv

// ==== tb_z80_bus_bridge.sv ====
// Z80 bus bridge testbench
`timescale 1ns/100ps
`default_nettype none

module tb_z80_bus_bridge;

  // All tests together take well under 500 clocks
  localparam int CYCLE_LIMIT = 4000;

  // Clocks from stb seen to ack with no wait_n stretching
  localparam int MEM_CLOCKS = 4;
  localparam int IO_CLOCKS = MEM_CLOCKS + 1;
  localparam int FETCH_CLOCKS = 5;

  // Expected strobe logs, bits are m1_n, mreq_n, iorq_n, rd_n, wr_n
  localparam logic [4:0] LOG_MEM_WR = 5'b01001;
  localparam logic [4:0] LOG_MEM_RD = 5'b01010;
  localparam logic [4:0] LOG_IO_WR = 5'b00101;
  localparam logic [4:0] LOG_IO_RD = 5'b00110;
  localparam logic [4:0] LOG_FETCH = 5'b11010;

  logic        clk;
  logic        reset_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [17:0] wb_adr;
  logic [7:0]  wb_dat_w;
  logic [7:0]  wb_dat_r;
  logic        wb_ack;
  logic        m1_n;
  logic        mreq_n;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic [15:0] addr;
  logic [7:0]  dout;
  logic [7:0]  din;
  logic        wait_n;
  logic [3:0]  wait_cycles;
  logic        log_clr;
  logic [4:0]  strobe_log;
  integer      seed = 32'h39b6cc32;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed = 0;
  int          cycle_count = 0;

  z80_bus_bridge dut (
    .clk      (clk),
    .reset_n  (reset_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .m1_n     (m1_n),
    .mreq_n   (mreq_n),
    .iorq_n   (iorq_n),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .addr     (addr),
    .dout     (dout),
    .din      (din),
    .wait_n   (wait_n)
  );

  tb_z80_bus_device dev (
    .clk         (clk),
    .reset_n     (reset_n),
    .m1_n        (m1_n),
    .mreq_n      (mreq_n),
    .iorq_n      (iorq_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .addr        (addr),
    .dout        (dout),
    .din         (din),
    .wait_n      (wait_n),
    .wait_cycles (wait_cycles),
    .log_clr     (log_clr),
    .strobe_log  (strobe_log)
  );

  always #5 clk = ~clk;

  // Ends a run that stops making progress
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] want,
                              input string what);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("[ERROR] %0t: %s, got %0h, expected %0h", $time, what, got, want);
    end
  endtask

  // Ack must never come while the device still stretches the cycle
  always @(negedge clk)
  begin
    if (reset_n && wb_ack)
      expect_equal(wait_n, 1'b1, "wait_n low while wb_ack is high");
  end

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before)
      $display("test %s: ok", name);
    else
    begin
      failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // One Wishbone classic transfer, clocks counted from stb seen to ack
  task automatic run_transfer(input logic we, input logic [17:0] adr, input logic [7:0] wdat,
                              output logic [7:0] rdat, output int clocks,
                              output logic [4:0] seen);
    int n;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    log_clr  = 1'b1;
    @(negedge clk);
    log_clr = 1'b0;
    n = 1;
    while (!wb_ack)
    begin
      @(negedge clk);
      n++;
    end
    rdat   = wb_dat_r;
    seen   = strobe_log;
    clocks = n - 1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reset_state_test();
    int base;
    int k;
    base = errors;
    for (k = 0; k < 16; k++)
    begin
      @(negedge clk);
      expect_equal({m1_n, mreq_n, iorq_n, rd_n, wr_n, wb_ack}, 6'b111110, "pins in reset");
    end
    reset_n = 1'b1;
    @(negedge clk);
    expect_equal({m1_n, mreq_n, iorq_n, rd_n, wr_n, wb_ack}, 6'b111110, "pins after reset");
    expect_equal(addr, 16'h0000, "addr after reset");
    expect_equal(dout, 8'h00, "dout after reset");
    report_test("reset state", base);
  endtask

  task automatic mem_write_read_test();
    logic [15:0] a [0:9];
    logic [7:0]  d [0:9];
    logic [7:0]  rdat;
    logic [4:0]  seen;
    logic [31:0] r;
    int          clocks;
    int          base;
    int          k;
    base = errors;
    wait_cycles = 4'd0;
    // Low nibble of the index keeps the ten addresses distinct
    for (k = 0; k < 10; k++)
    begin
      r = $random(seed);
      a[k] = {r[15:4], k[3:0]};
      d[k] = r[23:16];
      run_transfer(1'b1, {z80_bus_pkg::SPACE_MEM, a[k]}, d[k], rdat, clocks, seen);
      expect_equal(seen, LOG_MEM_WR, "memory write strobes");
      expect_equal(clocks, MEM_CLOCKS, "memory write clocks");
    end
    for (k = 0; k < 10; k++)
    begin
      run_transfer(1'b0, {z80_bus_pkg::SPACE_MEM, a[k]}, 8'h00, rdat, clocks, seen);
      expect_equal(rdat, d[k], "memory read data");
      expect_equal(seen, LOG_MEM_RD, "memory read strobes");
      expect_equal(clocks, MEM_CLOCKS, "memory read clocks");
    end
    report_test("memory write and read", base);
  endtask

  task automatic io_write_read_test();
    logic [7:0]  p [0:9];
    logic [7:0]  d [0:9];
    logic [7:0]  rdat;
    logic [4:0]  seen;
    logic [31:0] r;
    int          clocks;
    int          base;
    int          k;
    base = errors;
    wait_cycles = 4'd0;
    // Upper address byte differs between write and read, ports decode the low byte
    for (k = 0; k < 10; k++)
    begin
      r = $random(seed);
      p[k] = {k[3:0], r[3:0]};
      d[k] = r[15:8];
      run_transfer(1'b1, {z80_bus_pkg::SPACE_IO, r[23:16], p[k]}, d[k], rdat, clocks, seen);
      expect_equal(seen, LOG_IO_WR, "I/O write strobes");
      expect_equal(clocks, IO_CLOCKS, "I/O write clocks");
    end
    for (k = 0; k < 10; k++)
    begin
      r = $random(seed);
      run_transfer(1'b0, {z80_bus_pkg::SPACE_IO, r[7:0], p[k]}, 8'h00, rdat, clocks, seen);
      expect_equal(rdat, d[k], "I/O read data");
      expect_equal(seen, LOG_IO_RD, "I/O read strobes");
      expect_equal(clocks, IO_CLOCKS, "I/O read clocks");
    end
    report_test("I/O write and read", base);
  endtask

  task automatic opcode_fetch_test();
    logic [15:0] a;
    logic [7:0]  d;
    logic [7:0]  rdat;
    logic [4:0]  seen;
    logic [31:0] r;
    int          clocks;
    int          base;
    int          k;
    base = errors;
    wait_cycles = 4'd0;
    for (k = 0; k < 8; k++)
    begin
      r = $random(seed);
      a = r[15:0];
      d = r[31:24];
      // Opcode bytes are placed straight into the device memory
      dev.mem[a] = d;
      run_transfer(1'b0, {z80_bus_pkg::SPACE_FETCH, a}, 8'h00, rdat, clocks, seen);
      expect_equal(rdat, d, "fetch data");
      expect_equal(seen, LOG_FETCH, "fetch strobes");
      expect_equal(clocks, FETCH_CLOCKS, "fetch clocks");
    end
    report_test("opcode fetch", base);
  endtask

  task automatic wait_stretch_test();
    int          waits [0:2];
    logic [15:0] a;
    logic [7:0]  d;
    logic [7:0]  rdat;
    logic [4:0]  seen;
    logic [31:0] r;
    int          clocks;
    int          base;
    int          k;
    int          w;
    base = errors;
    waits[0] = 0;
    waits[1] = 3;
    waits[2] = 7;
    for (k = 0; k < 3; k++)
    begin
      w = waits[k];
      r = $random(seed);
      a = r[15:0];
      d = r[23:16];
      dev.mem[a] = d;
      wait_cycles = w;
      run_transfer(1'b0, {z80_bus_pkg::SPACE_MEM, a}, 8'h00, rdat, clocks, seen);
      expect_equal(rdat, d, "stretched memory read data");
      // Every wait_n low clock adds one wait state to a memory read
      expect_equal(clocks, MEM_CLOCKS + w, "stretched memory read clocks");
      d = ~r[31:24];
      run_transfer(1'b1, {z80_bus_pkg::SPACE_IO, a}, d, rdat, clocks, seen);
      // The automatic I/O wait covers the first clock of wait_n low
      expect_equal(clocks, IO_CLOCKS + ((w > 0) ? w - 1 : 0), "stretched I/O write clocks");
      wait_cycles = 4'd0;
      run_transfer(1'b0, {z80_bus_pkg::SPACE_IO, a}, 8'h00, rdat, clocks, seen);
      expect_equal(rdat, d, "stretched I/O write data");
    end
    report_test("wait stretching", base);
  endtask

  task automatic illegal_access_test();
    logic [7:0]  rdat;
    logic [4:0]  seen;
    int          clocks;
    int          base;
    base = errors;
    wait_cycles = 4'd0;
    // No bus cycle runs, so the ack comes on the same edge that sees stb
    run_transfer(1'b1, {z80_bus_pkg::SPACE_FETCH, 16'h1234}, 8'hc3, rdat, clocks, seen);
    expect_equal(rdat, 8'h00, "fetch space write data");
    expect_equal(seen, 5'b00000, "fetch space write strobes");
    expect_equal(clocks, 0, "fetch space write clocks");
    run_transfer(1'b0, {2'b11, 16'hbeef}, 8'h00, rdat, clocks, seen);
    expect_equal(rdat, 8'h00, "space 11 read data");
    expect_equal(seen, 5'b00000, "space 11 read strobes");
    expect_equal(clocks, 0, "space 11 read clocks");
    report_test("illegal access", base);
  endtask

  initial
  begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = 18'h00000;
    wb_dat_w    = 8'h00;
    wait_cycles = 4'd0;
    log_clr     = 1'b0;
    reset_state_test();
    mem_write_read_test();
    io_write_read_test();
    opcode_fetch_test();
    wait_stretch_test();
    illegal_access_test();
    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_z80_bus_device.sv ====
// Z80 bus memory and I/O model
`timescale 1ns/100ps
`default_nettype none

module tb_z80_bus_device (
  input  wire        clk,
  input  wire        reset_n,
  input  wire        m1_n,
  input  wire        mreq_n,
  input  wire        iorq_n,
  input  wire        rd_n,
  input  wire        wr_n,
  input  wire [15:0] addr,
  input  wire [7:0]  dout,
  output logic [7:0] din,
  output logic       wait_n,
  input  wire [3:0]  wait_cycles,
  input  wire        log_clr,
  output logic [4:0] strobe_log
);

  // 64 KiB memory and 256 I/O ports keyed on the low address byte
  logic [7:0] mem [0:65535];
  logic [7:0] ports [0:255];
  logic [3:0] held;
  logic       selected;
  int         i;

  // Fill patterns use every address bit so aliasing shows up as bad data
  initial
  begin
    for (i = 0; i < 65536; i++)
      mem[i] = i[15:8] ^ {i[6:0], i[7]} ^ 8'h3c;
    for (i = 0; i < 256; i++)
      ports[i] = ~i[7:0] ^ {i[3:0], i[7:4]};
  end

  assign selected = !mreq_n || !iorq_n;

  // The device holds wait_n low for the first wait_cycles clocks of a cycle
  assign wait_n = !(selected && (held < wait_cycles));

  // Read data follows the address while rd_n is low, bus floats high otherwise
  assign din = (!mreq_n && !rd_n) ? mem[addr] :
               (!iorq_n && !rd_n) ? ports[addr[7:0]] : 8'hff;

  // Counts clocks of the current cycle and gathers the strobes seen low
  // Log bits are m1_n, mreq_n, iorq_n, rd_n, wr_n from high to low
  always @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      held       <= 4'd0;
      strobe_log <= 5'b00000;
    end
    else
    begin
      if (!selected)
        held <= 4'd0;
      else if (held != 4'hf)
        held <= held + 4'd1;
      if (log_clr)
        strobe_log <= 5'b00000;
      else
        strobe_log <= strobe_log | ~{m1_n, mreq_n, iorq_n, rd_n, wr_n};
    end
  end

  // Writes land on every clock that wr_n is low, address and data are steady
  always @(posedge clk)
  begin
    if (!wr_n && !mreq_n)
      mem[addr] = dout;
    if (!wr_n && !iorq_n)
      ports[addr[7:0]] = dout;
  end

endmodule

`default_nettype wire

// ==== z80_bus_bridge.sv ====
// Wishbone to Z80 bus bridge
`timescale 1ns/100ps
`default_nettype none

module z80_bus_bridge (
  input  wire         clk,
  input  wire         reset_n,
  input  wire         wb_cyc,
  input  wire         wb_stb,
  input  wire         wb_we,
  input  wire  [17:0] wb_adr,
  input  wire  [7:0]  wb_dat_w,
  output logic [7:0]  wb_dat_r,
  output logic        wb_ack,
  output logic        m1_n,
  output logic        mreq_n,
  output logic        iorq_n,
  output logic        rd_n,
  output logic        wr_n,
  output logic [15:0] addr,
  output logic [7:0]  dout,
  input  wire  [7:0]  din,
  input  wire         wait_n
);

  logic                    req_valid;
  logic                    req_taken;
  z80_bus_pkg::bus_req_t   req;
  z80_bus_pkg::bus_phase_t phase;
  logic                    cycle_done;
  logic [7:0]              rdata;

  // Wishbone side, one request per transfer
  z80_req_intake u_intake (
    .clk        (clk),
    .reset_n    (reset_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .req_valid  (req_valid),
    .req        (req),
    .req_taken  (req_taken),
    .cycle_done (cycle_done),
    .rdata      (rdata)
  );

  // T-state stepping with wait_n stretching
  z80_tstate_seq u_seq (
    .clk       (clk),
    .reset_n   (reset_n),
    .req_valid (req_valid),
    .req       (req),
    .req_taken (req_taken),
    .wait_n    (wait_n),
    .phase     (phase)
  );

  // Registered pin drive and read data capture
  z80_strobe_gen u_strobe (
    .clk        (clk),
    .reset_n    (reset_n),
    .phase      (phase),
    .wait_n     (wait_n),
    .din        (din),
    .m1_n       (m1_n),
    .mreq_n     (mreq_n),
    .iorq_n     (iorq_n),
    .rd_n       (rd_n),
    .wr_n       (wr_n),
    .addr       (addr),
    .dout       (dout),
    .cycle_done (cycle_done),
    .rdata      (rdata)
  );

endmodule

`default_nettype wire

// ==== z80_strobe_gen.sv ====
// Z80 bus strobe generator
`timescale 1ns/100ps
`default_nettype none

module z80_strobe_gen (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire z80_bus_pkg::bus_phase_t phase,
  input  wire                        wait_n,
  input  wire  [7:0]                 din,
  output logic                       m1_n,
  output logic                       mreq_n,
  output logic                       iorq_n,
  output logic                       rd_n,
  output logic                       wr_n,
  output logic [15:0]                addr,
  output logic [7:0]                 dout,
  output logic                       cycle_done,
  output logic [7:0]                 rdata
);

  z80_bus_pkg::tstate_e   ts;
  z80_bus_pkg::bus_kind_e kind;
  logic                   active;
  logic                   data_phase;
  logic                   wr_window;
  logic                   last_ts;
  logic                   write_kind;

  assign ts         = phase.ts;
  assign kind       = phase.req.kind;
  assign write_kind = z80_bus_pkg::is_write(kind);

  // Strobes are asserted from T1 through the waits, seen one clock later
  assign active = ts inside {z80_bus_pkg::t1, z80_bus_pkg::t2,
                             z80_bus_pkg::tw_auto, z80_bus_pkg::tw};

  // T2 and any wait state, where read data may be sampled
  assign data_phase = ts inside {z80_bus_pkg::t2, z80_bus_pkg::tw_auto,
                                 z80_bus_pkg::tw};

  // Late write timing skips T1 and so lowers wr_n one clock later
  assign wr_window = z80_bus_pkg::WR_IN_T2 ? active : data_phase;

  // Fetch ends after T4, every other kind after T3
  assign last_ts = (ts == z80_bus_pkg::t4) ||
                   ((ts == z80_bus_pkg::t3) && (kind != z80_bus_pkg::fetch));

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      m1_n       <= 1'b1;
      mreq_n     <= 1'b1;
      iorq_n     <= 1'b1;
      rd_n       <= 1'b1;
      wr_n       <= 1'b1;
      addr       <= 16'h0000;
      dout       <= 8'h00;
      cycle_done <= 1'b0;
    end
    else
    begin
      // Every strobe idles high and is pulled low only when the phase asks
      m1_n       <= 1'b1;
      mreq_n     <= 1'b1;
      iorq_n     <= 1'b1;
      rd_n       <= 1'b1;
      wr_n       <= 1'b1;
      cycle_done <= last_ts;
      if (active)
      begin
        case (kind)
          z80_bus_pkg::fetch:
          begin
            m1_n   <= 1'b0;
            mreq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
          z80_bus_pkg::mem_rd:
          begin
            mreq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
          z80_bus_pkg::mem_wr:
          begin
            mreq_n <= 1'b0;
            if (wr_window)
              wr_n <= 1'b0;
          end
          z80_bus_pkg::io_rd:
          begin
            iorq_n <= 1'b0;
            rd_n   <= 1'b0;
          end
          z80_bus_pkg::io_wr:
          begin
            iorq_n <= 1'b0;
            if (wr_window)
              wr_n <= 1'b0;
          end
          default:
          begin
            mreq_n <= 1'b1;
          end
        endcase
      end
      // Address and write data stay put between cycles
      if (ts != z80_bus_pkg::idle)
        addr <= phase.req.addr;
      if ((ts != z80_bus_pkg::idle) && write_kind)
        dout <= phase.req.wdata;
    end
  end

  // Later samples overwrite earlier ones, so the last ready clock wins
  always_ff @(posedge clk)
  begin
    if (data_phase && wait_n && !write_kind)
      rdata <= din;
  end

endmodule

`default_nettype wire

// ==== z80_tstate_seq.sv ====
// Z80 T-state sequencer
`timescale 1ns/100ps
`default_nettype none

module z80_tstate_seq (
  input  wire                      clk,
  input  wire                      reset_n,
  input  wire                      req_valid,
  input  wire z80_bus_pkg::bus_req_t req,
  output logic                     req_taken,
  input  wire                      wait_n,
  output z80_bus_pkg::bus_phase_t  phase
);

  z80_bus_pkg::tstate_e  ts_q;
  z80_bus_pkg::tstate_e  ts_next;
  z80_bus_pkg::bus_req_t req_q;
  logic                  io_kind;
  logic                  fetch_kind;

  // A request is taken only from idle, which is the move into T1
  assign req_taken = (ts_q == z80_bus_pkg::idle) && req_valid;

  assign io_kind    = z80_bus_pkg::is_io(req_q.kind);
  assign fetch_kind = (req_q.kind == z80_bus_pkg::fetch);

  // One T-state per clock, waits sampled at the end of T2, auto wait and TW
  always_comb
  begin
    ts_next = ts_q;
    case (ts_q)
      z80_bus_pkg::idle:
      begin
        if (req_valid)
          ts_next = z80_bus_pkg::t1;
      end
      z80_bus_pkg::t1:
      begin
        ts_next = z80_bus_pkg::t2;
      end
      z80_bus_pkg::t2:
      begin
        // I/O gets its automatic wait before wait_n counts
        if (io_kind && z80_bus_pkg::IO_AUTO_WAIT)
          ts_next = z80_bus_pkg::tw_auto;
        else if (!wait_n)
          ts_next = z80_bus_pkg::tw;
        else
          ts_next = z80_bus_pkg::t3;
      end
      z80_bus_pkg::tw_auto:
      begin
        ts_next = wait_n ? z80_bus_pkg::t3 : z80_bus_pkg::tw;
      end
      z80_bus_pkg::tw:
      begin
        // Stay until the device releases wait_n
        if (wait_n)
          ts_next = z80_bus_pkg::t3;
      end
      z80_bus_pkg::t3:
      begin
        // Only the opcode fetch runs a fourth T-state
        ts_next = fetch_kind ? z80_bus_pkg::t4 : z80_bus_pkg::idle;
      end
      z80_bus_pkg::t4:
      begin
        ts_next = z80_bus_pkg::idle;
      end
      default:
      begin
        ts_next = z80_bus_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      ts_q <= z80_bus_pkg::idle;
    else
      ts_q <= ts_next;
  end

  // Request is captured on entry to T1 and held for the whole cycle
  always_ff @(posedge clk)
  begin
    if (req_taken)
      req_q <= req;
  end

  assign phase.req = req_q;
  assign phase.ts  = ts_q;

endmodule

`default_nettype wire

// ==== z80_req_intake.sv ====
// Wishbone request intake
`timescale 1ns/100ps
`default_nettype none

module z80_req_intake (
  input  wire                     clk,
  input  wire                     reset_n,
  input  wire                     wb_cyc,
  input  wire                     wb_stb,
  input  wire                     wb_we,
  input  wire  [17:0]             wb_adr,
  input  wire  [7:0]              wb_dat_w,
  output logic [7:0]              wb_dat_r,
  output logic                    wb_ack,
  output logic                    req_valid,
  output z80_bus_pkg::bus_req_t   req,
  input  wire                     req_taken,
  input  wire                     cycle_done,
  input  wire  [7:0]              rdata
);

  logic                   busy;
  logic                   legal;
  logic                   start;
  logic [1:0]             space;
  z80_bus_pkg::bus_kind_e kind;

  assign space = wb_adr[17:16];

  // Space code and direction pick the machine cycle kind
  always_comb
  begin
    kind  = z80_bus_pkg::mem_rd;
    legal = 1'b1;
    case (space)
      z80_bus_pkg::SPACE_FETCH:
      begin
        kind  = z80_bus_pkg::fetch;
        // Opcode fetch is read only
        legal = !wb_we;
      end
      z80_bus_pkg::SPACE_MEM:
      begin
        kind = wb_we ? z80_bus_pkg::mem_wr : z80_bus_pkg::mem_rd;
      end
      z80_bus_pkg::SPACE_IO:
      begin
        kind = wb_we ? z80_bus_pkg::io_wr : z80_bus_pkg::io_rd;
      end
      default:
      begin
        legal = 1'b0;
      end
    endcase
  end

  // A new transfer is seen only when idle and not in the ack clock
  assign start = wb_cyc && wb_stb && !busy && !wb_ack;

  // Held by the master until ack, so the request stays steady until taken
  assign req_valid  = start && legal;
  assign req.kind   = kind;
  assign req.addr   = wb_adr[15:0];
  assign req.wdata  = wb_dat_w;

  // Busy covers the span from launch to ack so one transfer runs one cycle
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      busy   <= 1'b0;
      wb_ack <= 1'b0;
    end
    else
    begin
      // Illegal accesses are acked at once with no bus cycle
      wb_ack <= cycle_done || (start && !legal);
      if (req_taken)
        busy <= 1'b1;
      else if (cycle_done)
        busy <= 1'b0;
    end
  end

  // Read data goes out with the ack, zero for an illegal access
  always_ff @(posedge clk)
  begin
    if (cycle_done)
      wb_dat_r <= rdata;
    else if (start && !legal)
      wb_dat_r <= 8'h00;
  end

endmodule

`default_nettype wire

// ==== z80_bus_pkg.sv ====
// Z80 bus bridge definitions
`default_nettype none

package z80_bus_pkg;

  // Address space codes carried in wb_adr[17:16]
  localparam logic [1:0] SPACE_MEM = 2'b00;
  localparam logic [1:0] SPACE_IO = 2'b01;
  localparam logic [1:0] SPACE_FETCH = 2'b10;

  // Write strobe timing, set drops wr_n from T2 and clear drops it only in T3
  localparam bit WR_IN_T2 = 1'b1;

  // I/O cycles get one automatic wait state after T2 when set
  localparam bit IO_AUTO_WAIT = 1'b1;

  // Machine cycle kinds run on the external bus
  typedef enum logic [2:0] {
    fetch  = 3'd0,
    mem_rd = 3'd1,
    mem_wr = 3'd2,
    io_rd  = 3'd3,
    io_wr  = 3'd4
  } bus_kind_e;

  // One bus request as handed from intake to the sequencer
  typedef struct packed {
    bus_kind_e   kind;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } bus_req_t;

  // Position of the bus inside a machine cycle
  typedef enum logic [2:0] {
    idle    = 3'd0,
    t1      = 3'd1,
    t2      = 3'd2,
    tw_auto = 3'd3,
    tw      = 3'd4,
    t3      = 3'd5,
    t4      = 3'd6
  } tstate_e;

  // Request plus its current T-state, sent to the strobe stage every clock
  typedef struct packed {
    bus_req_t req;
    tstate_e  ts;
  } bus_phase_t;

  // True for cycles that use iorq_n instead of mreq_n
  function automatic logic is_io(input bus_kind_e kind);
    return (kind == io_rd) || (kind == io_wr);
  endfunction

  // True for cycles that drive dout and pulse wr_n
  function automatic logic is_write(input bus_kind_e kind);
    return (kind == mem_wr) || (kind == io_wr);
  endfunction

endpackage

`default_nettype wire
